// ==== design/rvPkg.sv ====
package rvPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [3:0]  aluCtrl_t;
    typedef logic [1:0]  resultSrc_t;
    typedef logic [2:0]  immSrc_t;
    typedef logic [1:0]  forward_t;

    // base opcodes of the supported subset
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;

    localparam aluCtrl_t ALU_ADD   = 4'd0;
    localparam aluCtrl_t ALU_SUB   = 4'd1;
    localparam aluCtrl_t ALU_AND   = 4'd2;
    localparam aluCtrl_t ALU_OR    = 4'd3;
    localparam aluCtrl_t ALU_XOR   = 4'd4;
    localparam aluCtrl_t ALU_SLT   = 4'd5;
    localparam aluCtrl_t ALU_SLTU  = 4'd6;
    localparam aluCtrl_t ALU_SLL   = 4'd7;
    localparam aluCtrl_t ALU_SRL   = 4'd8;
    localparam aluCtrl_t ALU_SRA   = 4'd9;
    localparam aluCtrl_t ALU_PASSB = 4'd10;

    // writeback sources
    localparam resultSrc_t RES_ALU = 2'd0;
    localparam resultSrc_t RES_MEM = 2'd1;
    localparam resultSrc_t RES_PC4 = 2'd2;

    localparam immSrc_t IMM_I = 3'd0;
    localparam immSrc_t IMM_S = 3'd1;
    localparam immSrc_t IMM_B = 3'd2;
    localparam immSrc_t IMM_U = 3'd3;
    localparam immSrc_t IMM_J = 3'd4;

    localparam forward_t FWD_REG = 2'd0;
    localparam forward_t FWD_WB  = 2'd1;
    localparam forward_t FWD_MEM = 2'd2;

    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;

endpackage

// ==== design/hazardIf.sv ====
`timescale 1ns/100ps

interface hazardIf;

    // register indices seen by each stage
    rvPkg::regAddr_t rs1D;
    rvPkg::regAddr_t rs2D;
    rvPkg::regAddr_t rs1E;
    rvPkg::regAddr_t rs2E;
    rvPkg::regAddr_t rdE;
    rvPkg::regAddr_t rdM;
    rvPkg::regAddr_t rdW;
    logic            regWriteM;
    logic            regWriteW;
    logic            loadE;
    logic            redirectE;

    // pipeline controls back to the core
    rvPkg::forward_t forwardA;
    rvPkg::forward_t forwardB;
    logic            stallF;
    logic            stallD;
    logic            flushD;
    logic            flushE;

    modport unit (
        input  rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW,
        input  regWriteM, regWriteW, loadE, redirectE,
        output forwardA, forwardB, stallF, stallD, flushD, flushE
    );

    modport core (
        output rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW,
        output regWriteM, regWriteW, loadE, redirectE,
        input  forwardA, forwardB, stallF, stallD, flushD, flushE
    );

endinterface

// ==== design/hazardUnit.sv ====
`timescale 1ns/100ps

module hazardUnit (
    hazardIf.unit hz
);

    logic loadUse;

    // the younger producer in memory wins over writeback
    function automatic rvPkg::forward_t pickForward(
        input rvPkg::regAddr_t rs,
        input rvPkg::regAddr_t rdM,
        input logic            regWriteM,
        input rvPkg::regAddr_t rdW,
        input logic            regWriteW
    );
        if (rs != '0 && regWriteM && rs == rdM) begin
            return rvPkg::FWD_MEM;
        end else if (rs != '0 && regWriteW && rs == rdW) begin
            return rvPkg::FWD_WB;
        end
        return rvPkg::FWD_REG;
    endfunction

    assign hz.forwardA = pickForward(hz.rs1E, hz.rdM, hz.regWriteM, hz.rdW, hz.regWriteW);
    assign hz.forwardB = pickForward(hz.rs2E, hz.rdM, hz.regWriteM, hz.rdW, hz.regWriteW);

    // load data only exists after the memory stage
    assign loadUse = hz.loadE && (hz.rdE != '0) &&
                     ((hz.rdE == hz.rs1D) || (hz.rdE == hz.rs2D));

    assign hz.stallF = loadUse;
    assign hz.stallD = loadUse;

    // taken transfer squashes fetch and decode slots
    assign hz.flushD = hz.redirectE;
    assign hz.flushE = hz.redirectE || loadUse;

endmodule

// ==== design/decodeUnit.sv ====
`timescale 1ns/100ps

module decodeUnit (
    input  rvPkg::word_t      instr,
    output logic              regWrite,
    output logic              memWrite,
    output logic              aluSrcB,
    output logic              aluSrcAPc,
    output logic              branch,
    output logic              jump,
    output logic              jumpReg,
    output rvPkg::resultSrc_t resultSrc,
    output rvPkg::aluCtrl_t   aluCtrl,
    output rvPkg::word_t      imm
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            useFunct;
    logic            passB;
    rvPkg::immSrc_t  immSrc;
    rvPkg::aluCtrl_t functOp;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // main control, anything unknown stays a bubble
    always_comb begin
        regWrite  = 1'b0;
        memWrite  = 1'b0;
        aluSrcB   = 1'b0;
        aluSrcAPc = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        jumpReg   = 1'b0;
        useFunct  = 1'b0;
        passB     = 1'b0;
        resultSrc = rvPkg::RES_ALU;
        immSrc    = rvPkg::IMM_I;
        case (opcode)
            rvPkg::OP_R: begin
                regWrite = 1'b1;
                useFunct = 1'b1;
            end
            rvPkg::OP_I: begin
                regWrite = 1'b1;
                aluSrcB  = 1'b1;
                useFunct = 1'b1;
            end
            rvPkg::OP_LOAD: begin
                regWrite  = 1'b1;
                aluSrcB   = 1'b1;
                resultSrc = rvPkg::RES_MEM;
            end
            rvPkg::OP_STORE: begin
                memWrite = 1'b1;
                aluSrcB  = 1'b1;
                immSrc   = rvPkg::IMM_S;
            end
            rvPkg::OP_BRANCH: begin
                branch = 1'b1;
                immSrc = rvPkg::IMM_B;
            end
            rvPkg::OP_JAL: begin
                regWrite  = 1'b1;
                jump      = 1'b1;
                resultSrc = rvPkg::RES_PC4;
                immSrc    = rvPkg::IMM_J;
            end
            rvPkg::OP_JALR: begin
                regWrite  = 1'b1;
                jump      = 1'b1;
                jumpReg   = 1'b1;
                resultSrc = rvPkg::RES_PC4;
            end
            rvPkg::OP_LUI: begin
                regWrite = 1'b1;
                aluSrcB  = 1'b1;
                passB    = 1'b1;
                immSrc   = rvPkg::IMM_U;
            end
            rvPkg::OP_AUIPC: begin
                regWrite  = 1'b1;
                aluSrcB   = 1'b1;
                aluSrcAPc = 1'b1;
                immSrc    = rvPkg::IMM_U;
            end
            default: ;
        endcase
    end

    // instr[5] separates register form from immediate form for sub
    always_comb begin
        case (funct3)
            3'b000:  functOp = (instr[5] && instr[30]) ? rvPkg::ALU_SUB : rvPkg::ALU_ADD;
            3'b001:  functOp = rvPkg::ALU_SLL;
            3'b010:  functOp = rvPkg::ALU_SLT;
            3'b011:  functOp = rvPkg::ALU_SLTU;
            3'b100:  functOp = rvPkg::ALU_XOR;
            3'b101:  functOp = instr[30] ? rvPkg::ALU_SRA : rvPkg::ALU_SRL;
            3'b110:  functOp = rvPkg::ALU_OR;
            default: functOp = rvPkg::ALU_AND;
        endcase
    end

    assign aluCtrl = passB ? rvPkg::ALU_PASSB : (useFunct ? functOp : rvPkg::ALU_ADD);

    always_comb begin
        case (immSrc)
            rvPkg::IMM_S: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rvPkg::IMM_B: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                 instr[11:8], 1'b0};
            rvPkg::IMM_U: imm = {instr[31:12], 12'b0};
            rvPkg::IMM_J: imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                 instr[30:21], 1'b0};
            default:      imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

endmodule

// ==== design/registerFile.sv ====
`timescale 1ns/100ps

module registerFile (
    input  logic            clk,
    input  logic            rstN,
    input  logic            we,
    input  rvPkg::regAddr_t waddr,
    input  rvPkg::word_t    wdata,
    input  rvPkg::regAddr_t raddr1,
    input  rvPkg::regAddr_t raddr2,
    output rvPkg::word_t    rdata1,
    output rvPkg::word_t    rdata2,
    input  rvPkg::regAddr_t dbgAddr,
    output rvPkg::word_t    dbgData
);

    rvPkg::word_t regs [32];

    // x0 is hardwired, a pending write shows through
    function automatic rvPkg::word_t readPort(input rvPkg::regAddr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (we && addr == waddr) begin
            return wdata;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdata1  = readPort(raddr1);
        rdata2  = readPort(raddr2);
        dbgData = readPort(dbgAddr);
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

// ==== design/executeUnit.sv ====
`timescale 1ns/100ps

module executeUnit (
    input  rvPkg::word_t    rd1,
    input  rvPkg::word_t    rd2,
    input  rvPkg::word_t    pcE,
    input  rvPkg::word_t    immE,
    input  rvPkg::word_t    aluResultM,
    input  rvPkg::word_t    resultW,
    input  rvPkg::forward_t forwardA,
    input  rvPkg::forward_t forwardB,
    input  rvPkg::aluCtrl_t aluCtrl,
    input  logic            aluSrcB,
    input  logic            aluSrcAPc,
    input  logic            branch,
    input  logic            jump,
    input  logic            jumpReg,
    input  logic [2:0]      funct3,
    output rvPkg::word_t    aluResult,
    output rvPkg::word_t    storeData,
    output rvPkg::word_t    target,
    output logic            redirect
);

    rvPkg::word_t fwdA;
    rvPkg::word_t srcA;
    rvPkg::word_t srcB;
    logic [4:0]   shamt;
    logic         taken;

    function automatic rvPkg::word_t pickOperand(
        input rvPkg::forward_t sel,
        input rvPkg::word_t    regVal,
        input rvPkg::word_t    memVal,
        input rvPkg::word_t    wbVal
    );
        case (sel)
            rvPkg::FWD_MEM: return memVal;
            rvPkg::FWD_WB:  return wbVal;
            default:        return regVal;
        endcase
    endfunction

    assign fwdA      = pickOperand(forwardA, rd1, aluResultM, resultW);
    assign storeData = pickOperand(forwardB, rd2, aluResultM, resultW);
    assign srcA      = aluSrcAPc ? pcE : fwdA;
    assign srcB      = aluSrcB ? immE : storeData;
    assign shamt     = srcB[4:0];

    always_comb begin
        case (aluCtrl)
            rvPkg::ALU_SUB:   aluResult = srcA - srcB;
            rvPkg::ALU_AND:   aluResult = srcA & srcB;
            rvPkg::ALU_OR:    aluResult = srcA | srcB;
            rvPkg::ALU_XOR:   aluResult = srcA ^ srcB;
            rvPkg::ALU_SLT:   aluResult = {31'b0, $signed(srcA) < $signed(srcB)};
            rvPkg::ALU_SLTU:  aluResult = {31'b0, srcA < srcB};
            rvPkg::ALU_SLL:   aluResult = srcA << shamt;
            rvPkg::ALU_SRL:   aluResult = srcA >> shamt;
            rvPkg::ALU_SRA:   aluResult = $unsigned($signed(srcA) >>> shamt);
            rvPkg::ALU_PASSB: aluResult = srcB;
            default:          aluResult = srcA + srcB;
        endcase
    end

    // compare the forwarded registers, not the alu operands
    always_comb begin
        case (funct3)
            3'b000:  taken = fwdA == storeData;
            3'b001:  taken = fwdA != storeData;
            3'b100:  taken = $signed(fwdA) < $signed(storeData);
            3'b101:  taken = $signed(fwdA) >= $signed(storeData);
            3'b110:  taken = fwdA < storeData;
            3'b111:  taken = fwdA >= storeData;
            default: taken = 1'b0;
        endcase
    end

    // jalr clears bit 0 of its sum
    assign target   = jumpReg ? ((fwdA + immE) & ~32'd1) : pcE + immE;
    assign redirect = jump || (branch && taken);

endmodule

// ==== design/dataMemory.sv ====
`timescale 1ns/100ps

module dataMemory (
    input  logic         clk,
    input  logic         we,
    input  logic [2:0]   funct3,
    input  rvPkg::word_t addr,
    input  rvPkg::word_t wdata,
    output rvPkg::word_t rdata
);

    rvPkg::word_t                         mem [rvPkg::DMEM_WORDS];
    logic [$clog2(rvPkg::DMEM_WORDS)-1:0] index;
    logic [1:0]                           lane;
    rvPkg::word_t                         word;
    logic [7:0]                           byteVal;

    assign index   = addr[$clog2(rvPkg::DMEM_WORDS)+1:2];
    assign lane    = addr[1:0];
    assign word    = mem[index];
    assign byteVal = word[8*lane +: 8];

    // funct3[1] marks a word access, otherwise one byte lane
    always_ff @(posedge clk) begin
        if (we) begin
            if (funct3[1]) begin
                mem[index] <= wdata;
            end else begin
                mem[index][8*lane +: 8] <= wdata[7:0];
            end
        end
    end

    // lbu has funct3[2] set
    always_comb begin
        if (funct3[1]) begin
            rdata = word;
        end else if (funct3[2]) begin
            rdata = {24'b0, byteVal};
        end else begin
            rdata = {{24{byteVal[7]}}, byteVal};
        end
    end

endmodule

// ==== design/pipelineCore.sv ====
`timescale 1ns/100ps

module pipelineCore (
    input  logic                                 clk,
    input  logic                                 rstN,
    input  logic                                 run,
    input  logic                                 progWe,
    input  logic [$clog2(rvPkg::IMEM_WORDS)-1:0] progAddr,
    input  rvPkg::word_t                         progData,
    input  rvPkg::regAddr_t                      dbgAddr,
    output rvPkg::word_t                         dbgData,
    output rvPkg::word_t                         pc
);

    hazardIf hz ();

    rvPkg::word_t imem [rvPkg::IMEM_WORDS];
    rvPkg::word_t instrF;

    // decode stage
    rvPkg::word_t      instrD, pcD, rd1D, rd2D, immD;
    logic              regWriteD, memWriteD, aluSrcBD, aluSrcAPcD;
    logic              branchD, jumpD, jumpRegD;
    rvPkg::resultSrc_t resultSrcD;
    rvPkg::aluCtrl_t   aluCtrlD;

    // execute stage
    logic              regWriteE, memWriteE, aluSrcBE, aluSrcAPcE;
    logic              branchE, jumpE, jumpRegE, redirectE;
    rvPkg::resultSrc_t resultSrcE;
    rvPkg::aluCtrl_t   aluCtrlE;
    logic [2:0]        funct3E;
    rvPkg::regAddr_t   rs1E, rs2E, rdE;
    rvPkg::word_t      rd1E, rd2E, pcE, immE;
    rvPkg::word_t      aluResultE, storeDataE, targetE;

    // memory stage
    logic              regWriteM, memWriteM;
    rvPkg::resultSrc_t resultSrcM;
    logic [2:0]        funct3M;
    rvPkg::regAddr_t   rdM;
    rvPkg::word_t      aluResultM, storeDataM, pc4M, readDataM;

    // writeback stage
    logic              regWriteW;
    rvPkg::resultSrc_t resultSrcW;
    rvPkg::regAddr_t   rdW;
    rvPkg::word_t      aluResultW, readDataW, pc4W, resultW;

    always_ff @(posedge clk) begin
        if (progWe) begin
            imem[progAddr] <= progData;
        end
    end

    assign instrF = imem[pc[$clog2(rvPkg::IMEM_WORDS)+1:2]];

    // a redirect still lands while run is low so the pipe drains
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else if (redirectE) begin
            pc <= targetE;
        end else if (run && !hz.stallF) begin
            pc <= pc + 32'd4;
        end
    end

    // all-zero word decodes as a bubble
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            instrD <= '0;
        end else if (hz.flushD || (!hz.stallD && !run)) begin
            instrD <= '0;
        end else if (!hz.stallD) begin
            instrD <= instrF;
        end
    end

    always_ff @(posedge clk) begin
        if (!hz.stallD) begin
            pcD <= pc;
        end
    end

    decodeUnit decoder (
        .instr(instrD), .regWrite(regWriteD), .memWrite(memWriteD),
        .aluSrcB(aluSrcBD), .aluSrcAPc(aluSrcAPcD), .branch(branchD),
        .jump(jumpD), .jumpReg(jumpRegD), .resultSrc(resultSrcD),
        .aluCtrl(aluCtrlD), .imm(immD)
    );

    registerFile regFile (
        .clk(clk), .rstN(rstN), .we(regWriteW), .waddr(rdW), .wdata(resultW),
        .raddr1(instrD[19:15]), .raddr2(instrD[24:20]),
        .rdata1(rd1D), .rdata2(rd2D), .dbgAddr(dbgAddr), .dbgData(dbgData)
    );

    // flush turns the execute slot into a bubble
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regWriteE <= 1'b0;
            memWriteE <= 1'b0;
            branchE   <= 1'b0;
            jumpE     <= 1'b0;
        end else begin
            regWriteE <= regWriteD && !hz.flushE;
            memWriteE <= memWriteD && !hz.flushE;
            branchE   <= branchD && !hz.flushE;
            jumpE     <= jumpD && !hz.flushE;
        end
    end

    always_ff @(posedge clk) begin
        jumpRegE   <= jumpRegD;
        aluSrcBE   <= aluSrcBD;
        aluSrcAPcE <= aluSrcAPcD;
        resultSrcE <= resultSrcD;
        aluCtrlE   <= aluCtrlD;
        funct3E    <= instrD[14:12];
        rs1E       <= instrD[19:15];
        rs2E       <= instrD[24:20];
        rdE        <= instrD[11:7];
        rd1E       <= rd1D;
        rd2E       <= rd2D;
        pcE        <= pcD;
        immE       <= immD;
    end

    executeUnit execute (
        .rd1(rd1E), .rd2(rd2E), .pcE(pcE), .immE(immE),
        .aluResultM(aluResultM), .resultW(resultW),
        .forwardA(hz.forwardA), .forwardB(hz.forwardB),
        .aluCtrl(aluCtrlE), .aluSrcB(aluSrcBE), .aluSrcAPc(aluSrcAPcE),
        .branch(branchE), .jump(jumpE), .jumpReg(jumpRegE), .funct3(funct3E),
        .aluResult(aluResultE), .storeData(storeDataE), .target(targetE),
        .redirect(redirectE)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regWriteM <= 1'b0;
            memWriteM <= 1'b0;
        end else begin
            regWriteM <= regWriteE;
            memWriteM <= memWriteE;
        end
    end

    always_ff @(posedge clk) begin
        resultSrcM <= resultSrcE;
        funct3M    <= funct3E;
        rdM        <= rdE;
        aluResultM <= aluResultE;
        storeDataM <= storeDataE;
        pc4M       <= pcE + 32'd4;
    end

    dataMemory dmem (
        .clk(clk), .we(memWriteM), .funct3(funct3M), .addr(aluResultM),
        .wdata(storeDataM), .rdata(readDataM)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regWriteW <= 1'b0;
        end else begin
            regWriteW <= regWriteM;
        end
    end

    always_ff @(posedge clk) begin
        resultSrcW <= resultSrcM;
        rdW        <= rdM;
        aluResultW <= aluResultM;
        readDataW  <= readDataM;
        pc4W       <= pc4M;
    end

    always_comb begin
        case (resultSrcW)
            rvPkg::RES_MEM: resultW = readDataW;
            rvPkg::RES_PC4: resultW = pc4W;
            default:        resultW = aluResultW;
        endcase
    end

    assign hz.rs1D      = instrD[19:15];
    assign hz.rs2D      = instrD[24:20];
    assign hz.rs1E      = rs1E;
    assign hz.rs2E      = rs2E;
    assign hz.rdE       = rdE;
    assign hz.rdM       = rdM;
    assign hz.rdW       = rdW;
    assign hz.regWriteM = regWriteM;
    assign hz.regWriteW = regWriteW;
    assign hz.loadE     = regWriteE && (resultSrcE == rvPkg::RES_MEM);
    assign hz.redirectE = redirectE;

    hazardUnit hazard (
        .hz(hz)
    );

endmodule

// ==== test/coreChecker.sv ====
`timescale 1ns/100ps

module coreChecker (
    input  logic            clk,
    input  logic            checkStart,
    input  rvPkg::word_t    dbgData,
    input  rvPkg::word_t    pc,
    output rvPkg::regAddr_t dbgAddr,
    output logic            checkDone,
    output int              mismatchCount
);

    // same layout as the stimulus side reads
    rvPkg::word_t fileWords [0:rvPkg::IMEM_WORDS + 31];

    task automatic compareWord(
        input string        name,
        input rvPkg::word_t expected,
        input rvPkg::word_t actual
    );
        if (actual !== expected) begin
            $display("mismatch at time %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
            mismatchCount = mismatchCount + 1;
        end
    endtask

    initial begin : checkFlow
        int           progLen;
        rvPkg::word_t expectedPc;
        dbgAddr      <= '0;
        checkDone    <= 1'b0;
        mismatchCount = 0;
        $readmemh("test/programInput.hex", fileWords);
        while (!checkStart) @(posedge clk);
        progLen = int'(fileWords[0]);
        // one register per cycle, read back half a cycle later
        for (int r = 1; r < 32; r++) begin
            dbgAddr <= r[4:0];
            @(negedge clk);
            compareWord($sformatf("x%0d", r), fileWords[progLen + r], dbgData);
            @(posedge clk);
        end
        // last program word jumps to itself
        expectedPc = 4 * (progLen - 1);
        compareWord("pc", expectedPc, pc);
        checkDone <= 1'b1;
    end

endmodule

// ==== test/coreTb.sv ====
`timescale 1ns/100ps

module coreTb;

    logic                                 clk;
    logic                                 rstN;
    logic                                 run;
    logic                                 progWe;
    logic [$clog2(rvPkg::IMEM_WORDS)-1:0] progAddr;
    rvPkg::word_t                         progData;
    rvPkg::regAddr_t                      dbgAddr;
    rvPkg::word_t                         dbgData;
    rvPkg::word_t                         pc;

    logic checkStart;
    logic checkDone;
    int   mismatchCount;
    int   otherErrors;
    int   cycleLimit;

    // length word, program words, then 31 expected register values
    rvPkg::word_t fileWords [0:rvPkg::IMEM_WORDS + 31];

    pipelineCore dut (
        .clk(clk), .rstN(rstN), .run(run), .progWe(progWe), .progAddr(progAddr),
        .progData(progData), .dbgAddr(dbgAddr), .dbgData(dbgData), .pc(pc)
    );

    coreChecker checkUnit (
        .clk(clk), .checkStart(checkStart), .dbgData(dbgData), .pc(pc),
        .dbgAddr(dbgAddr), .checkDone(checkDone), .mismatchCount(mismatchCount)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // program goes in one word per cycle while the core is stopped
    task automatic loadProgram(input int progLen);
        for (int i = 0; i < progLen; i++) begin
            @(posedge clk);
            progWe   <= 1'b1;
            progAddr <= i[$clog2(rvPkg::IMEM_WORDS)-1:0];
            progData <= fileWords[i + 1];
        end
        @(posedge clk);
        progWe <= 1'b0;
    endtask

    task automatic runProgram(input int progLen);
        int runCycles;
        runCycles  = 3 * progLen + 40;
        cycleLimit = runCycles + 100;
        @(posedge clk);
        run <= 1'b1;
        repeat (runCycles) @(posedge clk);
        run <= 1'b0;
        // in-flight instructions retire through decode to writeback
        repeat (4) @(posedge clk);
    endtask

    initial begin : mainFlow
        int progLen;
        rstN       <= 1'b0;
        run        <= 1'b0;
        progWe     <= 1'b0;
        progAddr   <= '0;
        progData   <= '0;
        checkStart <= 1'b0;
        otherErrors = 0;
        cycleLimit  = 0;
        $readmemh("test/programInput.hex", fileWords);
        progLen = int'(fileWords[0]);
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        if ($isunknown(fileWords[0]) || progLen < 1 || progLen > rvPkg::IMEM_WORDS) begin
            $display("input file gives no usable program length, so nothing was run");
            otherErrors = otherErrors + 1;
        end else begin
            loadProgram(progLen);
            runProgram(progLen);
            checkStart <= 1'b1;
            while (!checkDone) @(posedge clk);
        end
        $display("summary: %0d mismatches, %0d other errors", mismatchCount, otherErrors);
        if (mismatchCount == 0 && otherErrors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // counts from the start of the run until the checker reports
    initial begin : watchdog
        int cycleCount;
        cycleCount = 0;
        @(posedge run);
        while (!checkDone && cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount = cycleCount + 1;
        end
        if (!checkDone) begin
            $display("timeout: checker gave no result within %0d cycles of run start",
                     cycleLimit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

endmodule

// ==== sim.f ====
design/rvPkg.sv
design/hazardIf.sv
design/hazardUnit.sv
design/decodeUnit.sv
design/registerFile.sv
design/executeUnit.sv
design/dataMemory.sv
design/pipelineCore.sv
test/coreChecker.sv
test/coreTb.sv

// ==== build.sh ====
#!/bin/sh
# compile with Verilator, run, then look for the pass line in the log
verilator --binary --timing --top-module coreTb -f sim.f -o coreSim \
    && ./obj_dir/coreSim | tee sim.log \
    && grep -qx "ALL CHECKS PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== test/programInput.hex ====
// word 0 is the program length, then the program words,
// then the expected final values of x1 to x31
0000002E  // 46 program words
00500093  // addi x1, x0, 5
FFD00113  // addi x2, x0, -3
002081B3  // add  x3, x1, x2
40208233  // sub  x4, x1, x2
001122B3  // slt  x5, x2, x1
00113333  // sltu x6, x2, x1
003093B3  // sll  x7, x1, x3
00315433  // srl  x8, x2, x3
403154B3  // sra  x9, x2, x3
00F0C513  // xori x10, x1, 15
07F17593  // andi x11, x2, 0x7f
00126633  // or   x12, x4, x1
004176B3  // and  x13, x2, x4
FFE12713  // slti x14, x2, -2
0060B793  // sltiu x15, x1, 6
12345837  // lui  x16, 0x12345
67880813  // addi x16, x16, 0x678
00001897  // auipc x17, 1
00708013  // addi x0, x1, 7
00100933  // add  x18, x0, x1
01002023  // sw   x16, 0(x0)
08000993  // addi x19, x0, 0x80
013000A3  // sb   x19, 1(x0)
00002A03  // lw   x20, 0(x0)
001A0AB3  // add  x21, x20, x1
00100B03  // lb   x22, 1(x0)
00104B83  // lbu  x23, 1(x0)
00300C03  // lb   x24, 3(x0)
00208463  // beq  x1, x2, +8
00100C93  // addi x25, x0, 1
00209463  // bne  x1, x2, +8
06300C93  // addi x25, x0, 99
00114463  // blt  x2, x1, +8
06300D13  // addi x26, x0, 99
00115463  // bge  x2, x1, +8
00200D13  // addi x26, x0, 2
00116463  // bltu x2, x1, +8
00300D93  // addi x27, x0, 3
00117463  // bgeu x2, x1, +8
06300D93  // addi x27, x0, 99
00800E6F  // jal  x28, +8
06300E93  // addi x29, x0, 99
0B400F13  // addi x30, x0, 180
001F0FE7  // jalr x31, 1(x30)
06300E93  // addi x29, x0, 99
0000006F  // jal  x0, 0
00000005  // x1
FFFFFFFD  // x2
00000002  // x3
00000008  // x4
00000001  // x5
00000000  // x6
00000014  // x7
3FFFFFFF  // x8
FFFFFFFF  // x9
0000000A  // x10
0000007D  // x11
0000000D  // x12
00000008  // x13
00000001  // x14
00000001  // x15
12345678  // x16
00001044  // x17
00000005  // x18
00000080  // x19
12348078  // x20
1234807D  // x21
FFFFFF80  // x22
00000080  // x23
00000012  // x24
00000001  // x25
00000002  // x26
00000003  // x27
000000A4  // x28
00000000  // x29
000000B4  // x30
000000B0  // x31
